/* Bender.yml */
package:
  name: rv_core

sources:
  - logic/rv_pkg.sv
  - logic/fetch_stage.sv
  - logic/decode_stage.sv
  - logic/reg_file.sv
  - logic/execute_stage.sv
  - logic/mem_wb_stage.sv
  - logic/rv_core_top.sv
  - target: test
    files:
      - test/tb_rv_core.sv

/* logic/decode_stage.sv */
`timescale 1ns/1ns

module decode_stage (
    input  logic                      ex_clk,
    input  logic                      ex_rst,
    input  logic [rv_pkg::xlen-1:0]   f_instr,
    input  logic [rv_pkg::xlen-1:0]   f_pc,
    input  logic                      f_ce,
    input  logic                      flush,
    input  logic                      ex_hold,
    output logic [rv_pkg::reg_aw-1:0] rs1_addr,
    output logic [rv_pkg::reg_aw-1:0] rs2_addr,
    input  logic [rv_pkg::xlen-1:0]   rs1_data,
    input  logic [rv_pkg::xlen-1:0]   rs2_data,
    output logic [rv_pkg::alu_w-1:0]  d_alu,
    output logic [rv_pkg::op_w-1:0]   d_opcode,
    output logic [2:0]                d_funct3,
    output logic [rv_pkg::reg_aw-1:0] d_addr_rs1,
    output logic [rv_pkg::reg_aw-1:0] d_addr_rs2,
    output logic [rv_pkg::reg_aw-1:0] d_addr_rd,
    output logic [rv_pkg::xlen-1:0]   d_data_rs1,
    output logic [rv_pkg::xlen-1:0]   d_data_rs2,
    output logic [rv_pkg::xlen-1:0]   d_imm,
    output logic [rv_pkg::xlen-1:0]   d_pc,
    output logic                      d_ce
);
    rv_pkg::opcode_e           opc;
    logic [rv_pkg::op_w-1:0]   opcode_1h;
    logic [rv_pkg::alu_w-1:0]  alu_1h;
    logic [rv_pkg::xlen-1:0]   imm;
    logic [2:0]                funct3;
    logic                      is_sub;

    assign opc    = rv_pkg::opcode_e'(f_instr[6:0]);
    assign funct3 = f_instr[14:12];
    assign is_sub = opcode_1h[rv_pkg::op_rtype] && f_instr[30];

    // During a hold the held instruction re-reads its sources, picking up late writebacks
    assign rs1_addr = ex_hold ? d_addr_rs1 : f_instr[19:15];
    assign rs2_addr = ex_hold ? d_addr_rs2 : f_instr[24:20];

    always_comb begin
        opcode_1h = '0;
        case (opc)
            rv_pkg::opc_rtype:  opcode_1h[rv_pkg::op_rtype] = 1'b1;
            rv_pkg::opc_itype:  opcode_1h[rv_pkg::op_itype] = 1'b1;
            rv_pkg::opc_load:   opcode_1h[rv_pkg::op_load] = 1'b1;
            rv_pkg::opc_store:  opcode_1h[rv_pkg::op_store] = 1'b1;
            rv_pkg::opc_branch: opcode_1h[rv_pkg::op_branch] = 1'b1;
            rv_pkg::opc_jal:    opcode_1h[rv_pkg::op_jal] = 1'b1;
            rv_pkg::opc_jalr:   opcode_1h[rv_pkg::op_jalr] = 1'b1;
            rv_pkg::opc_lui:    opcode_1h[rv_pkg::op_lui] = 1'b1;
            rv_pkg::opc_auipc:  opcode_1h[rv_pkg::op_auipc] = 1'b1;
            rv_pkg::opc_system: opcode_1h[rv_pkg::op_system] = 1'b1;
            rv_pkg::opc_fence:  opcode_1h[rv_pkg::op_fence] = 1'b1;
            default:            opcode_1h = '0;
        endcase
    end

    always_comb begin
        alu_1h = '0;
        if (opcode_1h[rv_pkg::op_rtype] || opcode_1h[rv_pkg::op_itype]) begin
            case (funct3)
                3'b000:  alu_1h[is_sub ? rv_pkg::alu_sub : rv_pkg::alu_add] = 1'b1;
                3'b001:  alu_1h[rv_pkg::alu_sll] = 1'b1;
                3'b010:  alu_1h[rv_pkg::alu_slt] = 1'b1;
                3'b011:  alu_1h[rv_pkg::alu_sltu] = 1'b1;
                3'b100:  alu_1h[rv_pkg::alu_xor] = 1'b1;
                3'b101:  alu_1h[f_instr[30] ? rv_pkg::alu_sra : rv_pkg::alu_srl] = 1'b1;
                3'b110:  alu_1h[rv_pkg::alu_or] = 1'b1;
                default: alu_1h[rv_pkg::alu_and] = 1'b1;
            endcase
        end else if (opcode_1h[rv_pkg::op_branch]) begin
            case (funct3)
                3'b000:  alu_1h[rv_pkg::alu_eq] = 1'b1;
                3'b001:  alu_1h[rv_pkg::alu_neq] = 1'b1;
                3'b100:  alu_1h[rv_pkg::alu_slt] = 1'b1;
                3'b101:  alu_1h[rv_pkg::alu_ge] = 1'b1;
                3'b110:  alu_1h[rv_pkg::alu_sltu] = 1'b1;
                3'b111:  alu_1h[rv_pkg::alu_geu] = 1'b1;
                default: alu_1h = '0;
            endcase
        end else begin
            // Address and target arithmetic
            alu_1h[rv_pkg::alu_add] = 1'b1;
        end
    end

    always_comb begin
        if (opcode_1h[rv_pkg::op_store]) begin
            imm = {{20{f_instr[31]}}, f_instr[31:25], f_instr[11:7]};
        end else if (opcode_1h[rv_pkg::op_branch]) begin
            imm = {{19{f_instr[31]}}, f_instr[31], f_instr[7], f_instr[30:25],
                   f_instr[11:8], 1'b0};
        end else if (opcode_1h[rv_pkg::op_lui] || opcode_1h[rv_pkg::op_auipc]) begin
            imm = {f_instr[31:12], 12'b0};
        end else if (opcode_1h[rv_pkg::op_jal]) begin
            imm = {{11{f_instr[31]}}, f_instr[31], f_instr[19:12], f_instr[20],
                   f_instr[30:21], 1'b0};
        end else begin
            imm = {{20{f_instr[31]}}, f_instr[31:20]};
        end
    end

    always_ff @(posedge ex_clk or negedge ex_rst) begin
        if (!ex_rst) begin
            d_ce     <= 1'b0;
            d_opcode <= '0;
            d_alu    <= '0;
        end else if (flush) begin
            d_ce <= 1'b0;
        end else if (!ex_hold) begin
            d_ce     <= f_ce;
            d_opcode <= opcode_1h;
            d_alu    <= alu_1h;
        end
    end

    always_ff @(posedge ex_clk) begin
        d_data_rs1 <= rs1_data;
        d_data_rs2 <= rs2_data;
        if (!ex_hold) begin
            d_funct3   <= funct3;
            d_addr_rs1 <= f_instr[19:15];
            d_addr_rs2 <= f_instr[24:20];
            d_addr_rd  <= f_instr[11:7];
            d_imm      <= imm;
            d_pc       <= f_pc;
        end
    end

    a_opcode_onehot: assert property (
        @(posedge ex_clk) disable iff (!ex_rst) $onehot0(d_opcode)
    ) else $error("d_opcode not one-hot: %b", d_opcode);

endmodule

/* logic/execute_stage.sv */
`timescale 1ns/1ns

module execute_stage (
    input  logic                      ex_clk,
    input  logic                      ex_rst,
    input  logic [rv_pkg::alu_w-1:0]  d_alu,
    input  logic [rv_pkg::op_w-1:0]   d_opcode,
    input  logic [2:0]                d_funct3,
    input  logic [rv_pkg::reg_aw-1:0] d_addr_rs1,
    input  logic [rv_pkg::reg_aw-1:0] d_addr_rs2,
    input  logic [rv_pkg::reg_aw-1:0] d_addr_rd,
    input  logic [rv_pkg::xlen-1:0]   d_data_rs1,
    input  logic [rv_pkg::xlen-1:0]   d_data_rs2,
    input  logic [rv_pkg::xlen-1:0]   d_imm,
    input  logic [rv_pkg::xlen-1:0]   d_pc,
    input  logic                      d_ce,
    input  logic                      wb_we,
    input  logic [rv_pkg::reg_aw-1:0] wb_rd,
    input  logic [rv_pkg::xlen-1:0]   wb_data,
    output logic [rv_pkg::op_w-1:0]   e_opcode,
    output logic [2:0]                e_funct3,
    output logic [rv_pkg::reg_aw-1:0] e_addr_rd,
    output logic [rv_pkg::xlen-1:0]   e_result,
    output logic [rv_pkg::xlen-1:0]   e_store_data,
    output logic                      e_we_reg,
    output logic                      e_ce,
    output logic                      change_pc,
    output logic [rv_pkg::xlen-1:0]   next_pc,
    output logic                      flush,
    output logic                      ex_hold
);
    logic [rv_pkg::xlen-1:0] rs1_val, rs2_val, op_a, op_b, alu_value, target;
    logic accept, cmp, taken, is_jump, is_mem, writes_rd;

    // Result still in execute beats the writeback value
    function automatic logic [rv_pkg::xlen-1:0] fwd(
        input logic [rv_pkg::reg_aw-1:0] src,
        input logic [rv_pkg::xlen-1:0]   rf_val
    );
        logic [rv_pkg::xlen-1:0] val;
        val = rf_val;
        if (src != '0 && wb_we && wb_rd == src) begin
            val = wb_data;
        end
        if (src != '0 && e_we_reg && e_addr_rd == src) begin
            val = e_result;
        end
        return val;
    endfunction

    always_comb begin
        rs1_val = fwd(d_addr_rs1, d_data_rs1);
        rs2_val = fwd(d_addr_rs2, d_data_rs2);
    end

    assign accept = d_ce && !flush && !ex_hold;
    assign op_a = (d_opcode[rv_pkg::op_jal] || d_opcode[rv_pkg::op_auipc]) ? d_pc :
                  d_opcode[rv_pkg::op_lui] ? '0 : rs1_val;
    assign op_b = (d_opcode[rv_pkg::op_rtype] || d_opcode[rv_pkg::op_branch]) ? rs2_val : d_imm;

    always_comb begin
        alu_value = '0;
        cmp = 1'b0;
        case (1'b1)
            d_alu[rv_pkg::alu_add]:  alu_value = op_a + op_b;
            d_alu[rv_pkg::alu_sub]:  alu_value = op_a - op_b;
            d_alu[rv_pkg::alu_xor]:  alu_value = op_a ^ op_b;
            d_alu[rv_pkg::alu_or]:   alu_value = op_a | op_b;
            d_alu[rv_pkg::alu_and]:  alu_value = op_a & op_b;
            d_alu[rv_pkg::alu_sll]:  alu_value = op_a << op_b[4:0];
            d_alu[rv_pkg::alu_srl]:  alu_value = op_a >> op_b[4:0];
            d_alu[rv_pkg::alu_sra]:  alu_value = $signed(op_a) >>> op_b[4:0];
            d_alu[rv_pkg::alu_slt]:  cmp = $signed(op_a) < $signed(op_b);
            d_alu[rv_pkg::alu_sltu]: cmp = op_a < op_b;
            d_alu[rv_pkg::alu_eq]:   cmp = op_a == op_b;
            d_alu[rv_pkg::alu_neq]:  cmp = op_a != op_b;
            d_alu[rv_pkg::alu_ge]:   cmp = $signed(op_a) >= $signed(op_b);
            d_alu[rv_pkg::alu_geu]:  cmp = op_a >= op_b;
            default:                 alu_value = '0;
        endcase
        if (cmp) begin
            alu_value = {{(rv_pkg::xlen-1){1'b0}}, 1'b1};
        end
    end

    // Comparison outcome sits in bit 0
    assign taken   = d_opcode[rv_pkg::op_branch] && alu_value[0];
    assign is_jump = d_opcode[rv_pkg::op_jal] || d_opcode[rv_pkg::op_jalr];
    assign is_mem  = d_opcode[rv_pkg::op_load] || d_opcode[rv_pkg::op_store];
    assign target  = d_opcode[rv_pkg::op_branch] ? d_pc + d_imm :
                     {alu_value[rv_pkg::xlen-1:1], 1'b0};
    assign writes_rd = d_opcode[rv_pkg::op_rtype] || d_opcode[rv_pkg::op_itype] ||
                       is_jump || d_opcode[rv_pkg::op_lui] || d_opcode[rv_pkg::op_auipc];

    always_ff @(posedge ex_clk or negedge ex_rst) begin
        if (!ex_rst) begin
            e_ce      <= 1'b0;
            e_we_reg  <= 1'b0;
            change_pc <= 1'b0;
            flush     <= 1'b0;
            ex_hold   <= 1'b0;
        end else begin
            e_ce      <= accept;
            e_we_reg  <= accept && writes_rd;
            change_pc <= accept && (taken || is_jump);
            flush     <= accept && (taken || is_jump);
            ex_hold   <= accept && is_mem;
        end
    end

    always_ff @(posedge ex_clk) begin
        if (accept) begin
            e_opcode     <= d_opcode;
            e_funct3     <= d_funct3;
            e_addr_rd    <= d_addr_rd;
            e_result     <= is_jump ? d_pc + rv_pkg::xlen'(4) : alu_value;
            e_store_data <= rs2_val;
            next_pc      <= target;
        end
    end

    a_flush_with_redirect: assert property (
        @(posedge ex_clk) disable iff (!ex_rst) flush |-> change_pc
    ) else $error("flush without change_pc");

    a_hold_one_cycle: assert property (
        @(posedge ex_clk) disable iff (!ex_rst) ex_hold |=> !ex_hold
    ) else $error("ex_hold high for two cycles");

endmodule

/* logic/fetch_stage.sv */
`timescale 1ns/1ns

module fetch_stage (
    input  logic                    ex_clk,
    input  logic                    ex_rst,
    input  logic                    change_pc,
    input  logic [rv_pkg::xlen-1:0] next_pc,
    input  logic                    ex_hold,
    output logic [rv_pkg::xlen-1:0] imem_addr,
    input  logic [rv_pkg::xlen-1:0] imem_data,
    output logic [rv_pkg::xlen-1:0] f_instr,
    output logic [rv_pkg::xlen-1:0] f_pc,
    output logic                    f_ce
);
    logic [rv_pkg::xlen-1:0] pc;

    // ROM is word addressed
    assign imem_addr = {2'b00, pc[rv_pkg::xlen-1:2]};

    always_ff @(posedge ex_clk or negedge ex_rst) begin
        if (!ex_rst) begin
            pc   <= '0;
            f_ce <= 1'b0;
        end else if (change_pc) begin
            // Word fetched this cycle is on the wrong path
            pc   <= next_pc;
            f_ce <= 1'b0;
        end else if (!ex_hold) begin
            pc   <= pc + rv_pkg::xlen'(4);
            f_ce <= 1'b1;
        end
    end

    always_ff @(posedge ex_clk) begin
        if (!ex_hold) begin
            f_instr <= imem_data;
            f_pc    <= pc;
        end
    end

endmodule

/* logic/mem_wb_stage.sv */
`timescale 1ns/1ns

module mem_wb_stage (
    input  logic                      ex_clk,
    input  logic                      ex_rst,
    input  logic [rv_pkg::op_w-1:0]   e_opcode,
    input  logic [2:0]                e_funct3,
    input  logic [rv_pkg::reg_aw-1:0] e_addr_rd,
    input  logic [rv_pkg::xlen-1:0]   e_result,
    input  logic [rv_pkg::xlen-1:0]   e_store_data,
    input  logic                      e_we_reg,
    input  logic                      e_ce,
    output logic                      wb_we,
    output logic [rv_pkg::reg_aw-1:0] wb_rd,
    output logic [rv_pkg::xlen-1:0]   wb_data
);
    logic [rv_pkg::xlen-1:0] dmem [0:rv_pkg::dmem_depth-1];
    logic [rv_pkg::dmem_aw-1:0] idx;
    logic word_acc, do_load;

    // Byte address to word index, wrapping over the array
    assign idx      = e_result[rv_pkg::dmem_aw+1:2];
    assign word_acc = e_funct3 == rv_pkg::f3_word;
    assign do_load  = e_opcode[rv_pkg::op_load] && word_acc;

    always_ff @(posedge ex_clk) begin
        if (e_ce && e_opcode[rv_pkg::op_store] && word_acc) begin
            dmem[idx] <= e_store_data;
        end
        wb_rd   <= e_addr_rd;
        wb_data <= do_load ? dmem[idx] : e_result;
    end

    always_ff @(posedge ex_clk or negedge ex_rst) begin
        if (!ex_rst) begin
            wb_we <= 1'b0;
        end else begin
            wb_we <= e_ce && (e_we_reg || do_load) && (e_addr_rd != '0);
        end
    end

    a_no_x0_write: assert property (
        @(posedge ex_clk) disable iff (!ex_rst) wb_we |-> wb_rd != '0
    ) else $error("writeback strobe to x0");

endmodule

/* logic/reg_file.sv */
`timescale 1ns/1ns

module reg_file (
    input  logic                      ex_clk,
    input  logic                      ex_rst,
    input  logic [rv_pkg::reg_aw-1:0] rs1_addr,
    input  logic [rv_pkg::reg_aw-1:0] rs2_addr,
    output logic [rv_pkg::xlen-1:0]   rs1_data,
    output logic [rv_pkg::xlen-1:0]   rs2_data,
    input  logic                      wb_we,
    input  logic [rv_pkg::reg_aw-1:0] wb_rd,
    input  logic [rv_pkg::xlen-1:0]   wb_data
);
    // x0 has no storage
    logic [rv_pkg::xlen-1:0] regs [1:31];

    always_ff @(posedge ex_clk or negedge ex_rst) begin
        if (!ex_rst) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_we && wb_rd != '0) begin
            regs[wb_rd] <= wb_data;
        end
    end

    // Same-cycle write is visible to the reader
    assign rs1_data = (rs1_addr == '0) ? '0 :
                      (wb_we && wb_rd == rs1_addr) ? wb_data : regs[rs1_addr];
    assign rs2_data = (rs2_addr == '0) ? '0 :
                      (wb_we && wb_rd == rs2_addr) ? wb_data : regs[rs2_addr];

endmodule

/* logic/rv_core_top.sv */
`timescale 1ns/1ns

module rv_core_top (
    input  logic                      ex_clk,
    input  logic                      ex_rst,
    output logic [rv_pkg::xlen-1:0]   imem_addr,
    input  logic [rv_pkg::xlen-1:0]   imem_data,
    output logic                      wb_we,
    output logic [rv_pkg::reg_aw-1:0] wb_rd,
    output logic [rv_pkg::xlen-1:0]   wb_data,
    output logic                      change_pc
);
    logic [rv_pkg::xlen-1:0]   next_pc, f_instr, f_pc;
    logic                      f_ce, flush, ex_hold;
    logic [rv_pkg::reg_aw-1:0] rs1_addr, rs2_addr;
    logic [rv_pkg::xlen-1:0]   rs1_data, rs2_data;

    // Decode to execute
    logic [rv_pkg::alu_w-1:0]  d_alu;
    logic [rv_pkg::op_w-1:0]   d_opcode;
    logic [2:0]                d_funct3;
    logic [rv_pkg::reg_aw-1:0] d_addr_rs1, d_addr_rs2, d_addr_rd;
    logic [rv_pkg::xlen-1:0]   d_data_rs1, d_data_rs2, d_imm, d_pc;
    logic                      d_ce;

    // Execute to memory and writeback
    logic [rv_pkg::op_w-1:0]   e_opcode;
    logic [2:0]                e_funct3;
    logic [rv_pkg::reg_aw-1:0] e_addr_rd;
    logic [rv_pkg::xlen-1:0]   e_result, e_store_data;
    logic                      e_we_reg, e_ce;

    fetch_stage   u_fetch   (.*);
    decode_stage  u_decode  (.*);
    reg_file      u_regs    (.*);
    execute_stage u_execute (.*);
    mem_wb_stage  u_mem_wb  (.*);

endmodule

/* logic/rv_pkg.sv */
package rv_pkg;

    localparam int xlen   = 32;
    localparam int reg_aw = 5;

    // One-hot ALU control bit positions
    localparam int alu_w    = 14;
    localparam int alu_add  = 0;
    localparam int alu_sub  = 1;
    localparam int alu_slt  = 2;
    localparam int alu_sltu = 3;
    localparam int alu_xor  = 4;
    localparam int alu_or   = 5;
    localparam int alu_and  = 6;
    localparam int alu_sll  = 7;
    localparam int alu_srl  = 8;
    localparam int alu_sra  = 9;
    localparam int alu_eq   = 10;
    localparam int alu_neq  = 11;
    localparam int alu_ge   = 12;
    localparam int alu_geu  = 13;

    // One-hot opcode bit positions
    localparam int op_w      = 11;
    localparam int op_rtype  = 0;
    localparam int op_itype  = 1;
    localparam int op_load   = 2;
    localparam int op_store  = 3;
    localparam int op_branch = 4;
    localparam int op_jal    = 5;
    localparam int op_jalr   = 6;
    localparam int op_lui    = 7;
    localparam int op_auipc  = 8;
    localparam int op_system = 9;
    localparam int op_fence  = 10;

    localparam int dmem_depth = 64;
    localparam int dmem_aw    = $clog2(dmem_depth);
    localparam logic [2:0] f3_word = 3'b010;

    typedef enum logic [6:0] {
        opc_load   = 7'b0000011,
        opc_fence  = 7'b0001111,
        opc_itype  = 7'b0010011,
        opc_auipc  = 7'b0010111,
        opc_store  = 7'b0100011,
        opc_rtype  = 7'b0110011,
        opc_lui    = 7'b0110111,
        opc_branch = 7'b1100011,
        opc_jalr   = 7'b1100111,
        opc_jal    = 7'b1101111,
        opc_system = 7'b1110011
    } opcode_e;

endpackage

/* tb.f */
logic/rv_pkg.sv
logic/fetch_stage.sv
logic/decode_stage.sv
logic/reg_file.sv
logic/execute_stage.sv
logic/mem_wb_stage.sv
logic/rv_core_top.sv
test/tb_rv_core.sv

/* test/tb_rv_core.sv */
`timescale 1ns/1ns

module tb_rv_core;

    logic                      ex_clk;
    logic                      ex_rst;
    logic [rv_pkg::xlen-1:0]   imem_addr;
    logic [rv_pkg::xlen-1:0]   imem_data;
    logic                      wb_we;
    logic [rv_pkg::reg_aw-1:0] wb_rd;
    logic [rv_pkg::xlen-1:0]   wb_data;
    logic                      change_pc;

    logic [31:0] rom [0:127];
    logic [31:0] expect_val [0:31];
    bit          poison [0:31];
    int          write_count [0:31];
    int          next_idx;
    int          halt_idx;
    int          value_errors;
    int          poison_errors;
    int          other_errors;

    rv_core_top u_dut (.*);

    // Combinational program ROM, word addressed
    assign imem_data = rom[imem_addr[6:0]];

    initial begin
        ex_clk = 1'b0;
        forever #50 ex_clk = ~ex_clk;
    end

    function automatic logic [31:0] r_type(input int f7, rs2, rs1, f3, rd);
        return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], rv_pkg::opc_rtype};
    endfunction

    function automatic logic [31:0] i_type(input rv_pkg::opcode_e opc, input int imm, rs1, f3, rd);
        return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], opc};
    endfunction

    function automatic logic [31:0] s_type(input int imm, rs2, rs1);
        return {imm[11:5], rs2[4:0], rs1[4:0], rv_pkg::f3_word, imm[4:0], rv_pkg::opc_store};
    endfunction

    function automatic logic [31:0] b_type(input int f3, rs1, rs2, off);
        return {off[12], off[10:5], rs2[4:0], rs1[4:0], f3[2:0], off[4:1], off[11],
                rv_pkg::opc_branch};
    endfunction

    function automatic logic [31:0] u_type(input rv_pkg::opcode_e opc, input int imm20, rd);
        return {imm20[19:0], rd[4:0], opc};
    endfunction

    function automatic logic [31:0] j_type(input int rd, off);
        return {off[20], off[10:1], off[11], off[19:12], rd[4:0], rv_pkg::opc_jal};
    endfunction

    task automatic emit(input logic [31:0] instr);
        rom[next_idx] = instr;
        next_idx++;
    endtask

    task automatic expect_write(input int rd, input logic [31:0] value);
        expect_val[rd] = value;
    endtask

    // Writes that a redirect must discard
    task automatic poison_pair();
        emit(i_type(rv_pkg::opc_itype, 1, 0, 0, 30));
        emit(i_type(rv_pkg::opc_itype, 2, 0, 0, 31));
    endtask

    task automatic branch_pair(input int f3, nt_a, nt_b, t_a, t_b, rd);
        emit(b_type(f3, nt_a, nt_b, 12));
        emit(i_type(rv_pkg::opc_itype, 100 + rd, 0, 0, rd));
        expect_write(rd, 100 + rd);
        emit(b_type(f3, t_a, t_b, 12));
        poison_pair();
    endtask

    task automatic build_program();
        int jalr_pc;
        for (int i = 0; i < 128; i++) begin
            // Spare words are no-ops tagged with their own address
            rom[i] = i_type(rv_pkg::opc_itype, i, 0, 0, 0);
        end
        for (int r = 0; r < 32; r++) begin
            expect_val[r] = '0;
            poison[r] = (r >= 30);
            write_count[r] = 0;
        end
        next_idx = 0;
        emit(i_type(rv_pkg::opc_itype, -7, 0, 0, 1));
        expect_write(1, 32'hffff_fff9);
        emit(i_type(rv_pkg::opc_itype, 3, 0, 0, 2));
        expect_write(2, 32'h0000_0003);
        emit(r_type(0, 2, 1, 0, 3));
        expect_write(3, 32'hffff_fffc);
        emit(r_type(32, 2, 3, 0, 4));
        expect_write(4, 32'hffff_fff9);
        emit(r_type(0, 2, 1, 2, 5));
        expect_write(5, 32'h0000_0001);
        emit(r_type(0, 2, 1, 3, 6));
        expect_write(6, 32'h0000_0000);
        emit(r_type(0, 2, 1, 4, 7));
        expect_write(7, 32'hffff_fffa);
        emit(r_type(0, 2, 1, 6, 8));
        expect_write(8, 32'hffff_fffb);
        emit(r_type(0, 2, 1, 7, 9));
        expect_write(9, 32'h0000_0001);
        emit(r_type(0, 2, 1, 1, 10));
        expect_write(10, 32'hffff_ffc8);
        emit(r_type(0, 2, 1, 5, 11));
        expect_write(11, 32'h1fff_ffff);
        emit(r_type(32, 2, 1, 5, 12));
        expect_write(12, 32'hffff_ffff);
        emit(u_type(rv_pkg::opc_lui, 'h12345, 13));
        expect_write(13, 32'h1234_5000);
        expect_write(14, next_idx * 4 + 32'h1000);
        emit(u_type(rv_pkg::opc_auipc, 1, 14));
        emit(i_type(rv_pkg::opc_itype, 5, 0, 0, 0));
        emit(i_type(rv_pkg::opc_itype, 'h678, 13, 0, 15));
        expect_write(15, 32'h1234_5678);
        // beq, bne, blt, bge, bltu, bgeu
        branch_pair(0, 1, 2, 4, 1, 16);
        branch_pair(1, 1, 4, 1, 2, 17);
        branch_pair(4, 2, 1, 1, 2, 18);
        branch_pair(5, 1, 2, 2, 1, 19);
        branch_pair(6, 1, 2, 2, 1, 20);
        branch_pair(7, 2, 1, 1, 2, 21);
        expect_write(22, next_idx * 4 + 4);
        emit(j_type(22, 12));
        poison_pair();
        jalr_pc = (next_idx + 1) * 4;
        emit(i_type(rv_pkg::opc_itype, jalr_pc + 1, 0, 0, 24));
        expect_write(24, jalr_pc + 1);
        expect_write(23, jalr_pc + 4);
        emit(i_type(rv_pkg::opc_jalr, 12, 24, 0, 23));
        poison_pair();
        // An odd PC after the JALR would show up here
        expect_write(25, next_idx * 4);
        emit(u_type(rv_pkg::opc_auipc, 0, 25));
        emit(s_type(8, 1, 0));
        emit(s_type(12, 7, 0));
        emit(s_type(40, 15, 0));
        emit(i_type(rv_pkg::opc_load, 8, 0, 2, 26));
        expect_write(26, 32'hffff_fff9);
        emit(r_type(0, 2, 26, 0, 27));
        expect_write(27, 32'hffff_fffc);
        emit(i_type(rv_pkg::opc_load, 12, 0, 2, 28));
        expect_write(28, 32'hffff_fffa);
        emit(i_type(rv_pkg::opc_load, 40, 0, 2, 29));
        expect_write(29, 32'h1234_5678);
        halt_idx = next_idx;
        emit(j_type(0, 0));
    endtask

    always @(negedge ex_clk) begin
        if (ex_rst && wb_we) begin
            write_count[wb_rd] <= write_count[wb_rd] + 1;
        end
    end

    a_wb_value: assert property (
        @(posedge ex_clk) disable iff (!ex_rst)
        wb_we && !poison[wb_rd] |-> wb_data == expect_val[wb_rd]
    ) else begin
        value_errors++;
        $display("Fail wb_data x%0d: got %h, expected %h", $sampled(wb_rd),
                 $sampled(wb_data), expect_val[$sampled(wb_rd)]);
    end

    a_no_poison: assert property (
        @(posedge ex_clk) disable iff (!ex_rst) wb_we |-> !poison[wb_rd]
    ) else begin
        poison_errors++;
        $display("Discarded instruction wrote register x%0d", $sampled(wb_rd));
    end

    a_no_x0: assert property (
        @(posedge ex_clk) disable iff (!ex_rst) wb_we |-> wb_rd != '0
    ) else begin
        other_errors++;
        $display("Writeback strobe raised for register x0");
    end

    initial begin
        int cycles;
        bit finished;
        bit redirect_seen;
        ex_rst = 1'b0;
        value_errors = 0;
        poison_errors = 0;
        other_errors = 0;
        build_program();
        repeat (10) @(posedge ex_clk);
        ex_rst <= 1'b1;
        finished = 1'b0;
        redirect_seen = 1'b0;
        // Done once the self-jump has redirected fetch back onto itself
        for (cycles = 0; cycles < 2000 && !finished; cycles++) begin
            @(negedge ex_clk);
            if (redirect_seen && imem_addr == halt_idx) begin
                finished = 1'b1;
            end
            redirect_seen = change_pc;
        end
        if (!finished) begin
            other_errors++;
            $display("Timeout: program did not finish within 2000 cycles");
        end
        for (int r = 1; r < 32; r++) begin
            if (!poison[r] && write_count[r] != 1) begin
                other_errors++;
                $display("Register x%0d written %0d times instead of once", r, write_count[r]);
            end
        end
        $display("Errors: value %0d, poison %0d, other %0d",
                 value_errors, poison_errors, other_errors);
        if (value_errors + poison_errors + other_errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule
